// File: design/oflow_macros.svh
// oflow tracking core constants
`ifndef OFLOW_MACROS_SVH
`define OFLOW_MACROS_SVH

// ----------------------------------------------------------------------
// field widths
// ----------------------------------------------------------------------
`define OFLOW_COORD_W        8   // x, y, w, h and color
`define OFLOW_ID_W           8   // track identifier
`define OFLOW_FRAME_W        8   // frame counter

// ----------------------------------------------------------------------
// limits
// ----------------------------------------------------------------------
`define OFLOW_MAX_BBOX       4   // boxes per frame = history entries
`define OFLOW_FIFO_DEPTH     4   // default feature fifo depth

// ----------------------------------------------------------------------
// matching
// ----------------------------------------------------------------------
`define OFLOW_MATCH_TH       16  // largest cost still counted as a match
`define OFLOW_COLOR_PENALTY  12  // added when colors differ
`define OFLOW_COST_W         11  // 4 * 255 + penalty fits in 11 bits

`endif

// File: design/oflow_pkg.sv
// oflow shared types
`include "oflow_macros.svh"

package oflow_pkg;

	// one bounding box as the DMA delivers it
	typedef struct packed {
		logic [`OFLOW_COORD_W-1:0] x;
		logic [`OFLOW_COORD_W-1:0] y;
		logic [`OFLOW_COORD_W-1:0] w;
		logic [`OFLOW_COORD_W-1:0] h;
		logic [`OFLOW_COORD_W-1:0] color;
		logic                      last;   // final box of the frame
	} bbox_t;

	// feature record, center point instead of corner
	typedef struct packed {
		logic [`OFLOW_COORD_W-1:0] cx;     // x + w/2, truncated
		logic [`OFLOW_COORD_W-1:0] cy;     // y + h/2, truncated
		logic [`OFLOW_COORD_W-1:0] w;
		logic [`OFLOW_COORD_W-1:0] h;
		logic [`OFLOW_COORD_W-1:0] color;
		logic                      last;
	} feat_t;

	// one result per box
	typedef struct packed {
		logic [`OFLOW_ID_W-1:0]    id;
		logic [`OFLOW_FRAME_W-1:0] frame_num;
		logic                      new_track;  // fresh id was handed out
		logic                      last;       // copied from the box
	} track_t;

endpackage

// File: design/oflow_feature_extract.sv
// oflow box receiver and feature stage
module oflow_feature_extract (
	input  logic              clk,
	input  logic              arst_n_i,

	// box input, four-phase
	input  logic              bbox_req_i,
	input  oflow_pkg::bbox_t  bbox_i,      // held steady while req is high
	output logic              bbox_ack_o,

	// feature fifo write side
	input  logic              fifo_full_i,
	output logic              fifo_push_o,
	output oflow_pkg::feat_t  fifo_data_o
);

	logic ack_q;  // ack state, also blocks a second push per request

	// ----------------------------------------------------------------------
	// feature computation
	// ----------------------------------------------------------------------

	// center = corner + half size, carry dropped
	always_comb begin
		fifo_data_o.cx    = bbox_i.x + (bbox_i.w >> 1);
		fifo_data_o.cy    = bbox_i.y + (bbox_i.h >> 1);
		fifo_data_o.w     = bbox_i.w;        // size passes through
		fifo_data_o.h     = bbox_i.h;
		fifo_data_o.color = bbox_i.color;
		fifo_data_o.last  = bbox_i.last;     // frame marker rides along
	end

	// ----------------------------------------------------------------------
	// push and handshake
	// ----------------------------------------------------------------------

	// one push per request: only while ack is still low
	// a full fifo simply delays the push, and with it the ack
	assign fifo_push_o = bbox_req_i & ~ack_q & ~fifo_full_i;

	// phase 1 -> 2: push seen, ack rises at the next edge
	// phase 3 -> 4: req seen low, ack falls at the next edge
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
		end else if (fifo_push_o) begin
			ack_q <= 1'b1;                     // record is in the fifo
		end else if (!bbox_req_i) begin
			ack_q <= 1'b0;                     // sender released
		end
	end

	assign bbox_ack_o = ack_q;

endmodule

// File: design/oflow_feature_fifo.sv
// oflow feature record fifo
`include "oflow_macros.svh"

module oflow_feature_fifo #(
	parameter int DEPTH = `OFLOW_FIFO_DEPTH
) (
	input  logic              clk,
	input  logic              arst_n_i,

	// write side, from the feature stage
	input  logic              push_i,
	input  oflow_pkg::feat_t  data_i,
	output logic              full_o,

	// read side, head is valid whenever not empty
	input  logic              pop_i,
	output oflow_pkg::feat_t  data_o,
	output logic              empty_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

	oflow_pkg::feat_t  mem [DEPTH];   // record storage
	logic [PTR_W-1:0]  wr_ptr_q;
	logic [PTR_W-1:0]  rd_ptr_q;
	logic [CNT_W-1:0]  count_q;       // occupancy
	logic              do_push;
	logic              do_pop;

	assign do_push = push_i & ~full_o;   // ignore writes when full
	assign do_pop  = pop_i & ~empty_o;   // ignore reads when empty

	// ----------------------------------------------------------------------
	// pointers and occupancy
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;  // wrap
			if (do_pop)
				rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
			if (do_push && !do_pop)
				count_q <= count_q + 1'b1;
			else if (do_pop && !do_push)
				count_q <= count_q - 1'b1;
		end
	end

	// storage, written on push
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr_q] <= data_i;
	end

	assign data_o  = mem[rd_ptr_q];              // head, one cycle after push
	assign full_o  = (count_q == CNT_W'(DEPTH));
	assign empty_o = (count_q == '0);

endmodule

// File: design/oflow_registration.sv
// oflow track registration stage
`include "oflow_macros.svh"

module oflow_registration (
	input  logic              clk,
	input  logic              arst_n_i,

	// feature fifo read side
	input  logic              fifo_empty_i,
	input  oflow_pkg::feat_t  fifo_data_i,
	output logic              fifo_pop_o,

	// result output, four-phase
	output logic              track_req_o,
	output oflow_pkg::track_t track_o,
	input  logic              track_ack_i
);

	localparam int MAX    = `OFLOW_MAX_BBOX;
	localparam int IDX_W  = $clog2(MAX);
	localparam int CNT_W  = IDX_W + 1;
	localparam int COST_W = `OFLOW_COST_W;
	localparam int ID_W   = `OFLOW_ID_W;

	// history entry: feature plus the id it was given
	typedef struct packed {
		oflow_pkg::feat_t  feat;
		logic [ID_W-1:0]   id;
	} hist_t;

	typedef enum logic [1:0] {ST_IDLE, ST_SCAN, ST_REQ, ST_REL} state_t;

	state_t                   state_q;
	oflow_pkg::feat_t         rec_q;          // record under scan
	oflow_pkg::track_t        track_q;
	hist_t                    prev_tab [MAX]; // tracks of the previous frame
	hist_t                    cur_tab  [MAX]; // tracks built in this frame
	logic [MAX-1:0]           prev_valid_q;
	logic [MAX-1:0]           prev_claim_q;   // first come takes the entry
	logic [MAX-1:0]           cur_valid_q;
	logic [CNT_W-1:0]         cur_cnt_q;      // next free current slot
	logic [IDX_W-1:0]         scan_idx_q;
	logic [IDX_W-1:0]         best_idx_q;
	logic [COST_W-1:0]        best_cost_q;
	logic [ID_W-1:0]          next_id_q;
	logic [`OFLOW_FRAME_W-1:0] frame_num_q;
	hist_t                    ent;
	logic [COST_W-1:0]        cost;
	logic                     cand_better;
	logic [COST_W-1:0]        nxt_cost;
	logic [IDX_W-1:0]         nxt_idx;
	logic                     scan_last;
	logic                     decide;         // last scan cycle
	logic                     is_match;
	logic [ID_W-1:0]          new_id;
	logic                     cur_full;
	logic                     swap;           // frame done, handshake closed

	function automatic logic [COST_W-1:0] abs_diff(
		input logic [`OFLOW_COORD_W-1:0] a,
		input logic [`OFLOW_COORD_W-1:0] b
	);
		return (a > b) ? COST_W'(a - b) : COST_W'(b - a);
	endfunction

	// ----------------------------------------------------------------------
	// similarity scan, one previous entry per cycle
	// ----------------------------------------------------------------------
	assign ent = prev_tab[scan_idx_q];

	always_comb begin
		cost = abs_diff(rec_q.cx, ent.feat.cx) + abs_diff(rec_q.cy, ent.feat.cy)
		     + abs_diff(rec_q.w, ent.feat.w) + abs_diff(rec_q.h, ent.feat.h);
		if (rec_q.color != ent.feat.color)
			cost = cost + COST_W'(`OFLOW_COLOR_PENALTY);   // color mismatch
	end

	// strict less, so the lower index keeps a tie
	assign cand_better = prev_valid_q[scan_idx_q] & ~prev_claim_q[scan_idx_q]
	                   & (cost < best_cost_q);
	assign nxt_cost  = cand_better ? cost : best_cost_q;
	assign nxt_idx   = cand_better ? scan_idx_q : best_idx_q;
	assign scan_last = (scan_idx_q == IDX_W'(MAX - 1));
	assign decide    = (state_q == ST_SCAN) & scan_last;
	assign is_match  = (nxt_cost <= COST_W'(`OFLOW_MATCH_TH));
	assign new_id    = is_match ? prev_tab[nxt_idx].id : next_id_q;
	assign cur_full  = (cur_cnt_q == CNT_W'(MAX));
	assign swap      = (state_q == ST_REL) & ~track_ack_i & track_q.last;

	assign fifo_pop_o  = (state_q == ST_IDLE) & ~fifo_empty_i;  // head read now
	assign track_req_o = (state_q == ST_REQ);
	assign track_o     = track_q;

	// ----------------------------------------------------------------------
	// control: fsm, flags, counters
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q      <= ST_IDLE;
			prev_valid_q <= '0;
			prev_claim_q <= '0;
			cur_valid_q  <= '0;
			cur_cnt_q    <= '0;
			scan_idx_q   <= '0;
			best_idx_q   <= '0;
			best_cost_q  <= '1;
			next_id_q    <= ID_W'(1);   // id 0 is never handed out
			frame_num_q  <= '0;
		end else begin
			case (state_q)
				ST_IDLE: if (fifo_pop_o) begin
					state_q     <= ST_SCAN;
					scan_idx_q  <= '0;
					best_cost_q <= '1;         // above any real cost
					best_idx_q  <= '0;
				end
				ST_SCAN: begin
					best_cost_q <= nxt_cost;
					best_idx_q  <= nxt_idx;
					scan_idx_q  <= scan_idx_q + 1'b1;
					if (scan_last) begin
						state_q <= ST_REQ;           // req rises next cycle
						if (is_match)
							prev_claim_q[nxt_idx] <= 1'b1;
						else
							next_id_q <= next_id_q + 1'b1;
						if (!cur_full) begin
							cur_valid_q[cur_cnt_q[IDX_W-1:0]] <= 1'b1;
							cur_cnt_q <= cur_cnt_q + 1'b1;
						end
					end
				end
				ST_REQ: if (track_ack_i) state_q <= ST_REL;   // drop req
				ST_REL: if (!track_ack_i) begin
					state_q <= ST_IDLE;
					if (track_q.last) begin      // roll history to next frame
						prev_valid_q <= cur_valid_q;
						prev_claim_q <= '0;
						cur_valid_q  <= '0;
						cur_cnt_q    <= '0;
						frame_num_q  <= frame_num_q + 1'b1;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// payload: record, result, tables
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (fifo_pop_o)
			rec_q <= fifo_data_i;
		if (decide) begin
			track_q.id        <= new_id;
			track_q.frame_num <= frame_num_q;
			track_q.new_track <= ~is_match;
			track_q.last      <= rec_q.last;
			if (!cur_full)
				cur_tab[cur_cnt_q[IDX_W-1:0]] <= '{feat: rec_q, id: new_id};
		end
		if (swap)
			prev_tab <= cur_tab;
	end

endmodule

// File: design/oflow_core.sv
// oflow tracking core top
`include "oflow_macros.svh"

module oflow_core (
	input  logic              clk,
	input  logic              arst_n_i,

	// box input from DMA, four-phase
	input  logic              bbox_req_i,
	input  oflow_pkg::bbox_t  bbox_i,
	output logic              bbox_ack_o,

	// track results, four-phase
	output logic              track_req_o,
	output oflow_pkg::track_t track_o,
	input  logic              track_ack_i
);

	// ----------------------------------------------------------------------
	// feature fifo links
	// ----------------------------------------------------------------------
	logic              fifo_push;
	logic              fifo_full;
	logic              fifo_pop;
	logic              fifo_empty;
	oflow_pkg::feat_t  push_data;   // producer -> fifo
	oflow_pkg::feat_t  head_data;   // fifo head -> consumer

	oflow_feature_extract u_feature_extract (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.bbox_req_i  (bbox_req_i),
		.bbox_i      (bbox_i),
		.bbox_ack_o  (bbox_ack_o),
		.fifo_full_i (fifo_full),
		.fifo_push_o (fifo_push),
		.fifo_data_o (push_data)
	);

	oflow_feature_fifo #(.DEPTH(`OFLOW_FIFO_DEPTH)) u_feature_fifo (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.push_i   (fifo_push),
		.data_i   (push_data),
		.full_o   (fifo_full),
		.pop_i    (fifo_pop),
		.data_o   (head_data),
		.empty_o  (fifo_empty)
	);

	oflow_registration u_registration (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.fifo_empty_i (fifo_empty),
		.fifo_data_i  (head_data),
		.fifo_pop_o   (fifo_pop),
		.track_req_o  (track_req_o),
		.track_o      (track_o),
		.track_ack_i  (track_ack_i)
	);

endmodule

// File: verif/oflow_core_checker.sv
// oflow handshake checker
module oflow_core_checker (
	input  logic              clk,
	input  logic              arst_n_i,
	input  logic              bbox_req_i,
	input  logic              bbox_ack_o,
	input  logic              track_req_o,
	input  logic              track_ack_i,
	input  oflow_pkg::track_t track_o
);

	timeunit 1ns;
	timeprecision 100ps;

	int fail_cnt = 0;   // failed assertions so far

	// ----------------------------------------------------------------------
	// four-phase rules on the box side and the result side
	// ----------------------------------------------------------------------

	// a waiting request is held until the ack comes up
	assert property (@(posedge clk) disable iff (!arst_n_i)
		(bbox_req_i && !bbox_ack_o) |=> (bbox_req_i || bbox_ack_o))
		else begin
			$error("bbox_req_i dropped before bbox_ack_o rose");
			fail_cnt++;
		end
	assert property (@(posedge clk) disable iff (!arst_n_i)
		(track_req_o && !track_ack_i) |=> (track_req_o || track_ack_i))
		else begin
			$error("track_req_o dropped before track_ack_i rose");
			fail_cnt++;
		end

	// ack only answers a live request
	// the box ack is registered, so its request was up one edge earlier
	assert property (@(posedge clk) disable iff (!arst_n_i)
		$rose(bbox_ack_o) |-> $past(bbox_req_i))
		else begin
			$error("bbox_ack_o rose without bbox_req_i");
			fail_cnt++;
		end
	assert property (@(posedge clk) disable iff (!arst_n_i)
		$rose(track_ack_i) |-> track_req_o)
		else begin
			$error("track_ack_i rose without track_req_o");
			fail_cnt++;
		end

	// result payload frozen while offered
	assert property (@(posedge clk) disable iff (!arst_n_i)
		track_req_o |=> (!track_req_o || $stable(track_o)))
		else begin
			$error("track_o changed while track_req_o high");
			fail_cnt++;
		end

	// outputs quiet in reset
	assert property (@(posedge clk) !arst_n_i |-> (!bbox_ack_o && !track_req_o))
		else begin
			$error("handshake output high during reset");
			fail_cnt++;
		end

endmodule

// File: verif/oflow_core_tb.sv
// oflow tracking core testbench
`include "oflow_macros.svh"

module oflow_core_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX           = `OFLOW_MAX_BBOX;
	localparam int N_BOXES       = 16;    // boxes over all tests
	localparam int MAX_ACK_DELAY = 7;     // cycles of ack delay in the back-pressure test
	localparam int IDLE_CYCLES   = 20;
	localparam int WATCHDOG_CYC  = N_BOXES * (40 + MAX_ACK_DELAY) + IDLE_CYCLES + 40;

	logic              clk;
	logic              arst_n_i;
	logic              bbox_req_i;
	oflow_pkg::bbox_t  bbox_i;
	logic              bbox_ack_o;
	logic              track_req_o;
	oflow_pkg::track_t track_o;
	logic              track_ack_i;

	int                seed = 32'h0a756a8a;
	int                err_cnt = 0;
	int                check_cnt = 0;
	int                test_cnt = 0;
	oflow_pkg::bbox_t  box_q [$];       // boxes of the test in progress

	// reference model state
	oflow_pkg::feat_t        m_prev_feat [MAX];
	logic [`OFLOW_ID_W-1:0]  m_prev_id   [MAX];
	logic                    m_prev_valid[MAX];
	logic                    m_claim     [MAX];
	oflow_pkg::feat_t        m_cur_feat  [MAX];
	logic [`OFLOW_ID_W-1:0]  m_cur_id    [MAX];
	int                      m_cur_cnt = 0;
	logic [`OFLOW_ID_W-1:0]  m_next_id = 1;
	logic [`OFLOW_FRAME_W-1:0] m_frame = 0;

	oflow_core u_dut (.*);

	bind oflow_core oflow_core_checker u_checker (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;   // 8 ns
	end

	// ----------------------------------------------------------------------
	// drivers and reference model
	// ----------------------------------------------------------------------
	task automatic next_cycle();   // drive and sample point 1 ns after the edge
		@(posedge clk);
		#1;
	endtask

	function automatic oflow_pkg::bbox_t build_box(input int x, y, w, h, color, last);
		oflow_pkg::bbox_t b;
		b = '{x: x, y: y, w: w, h: h, color: color, last: last};
		return b;
	endfunction

	task automatic send_box(input oflow_pkg::bbox_t b);
		bbox_i     = b;
		bbox_req_i = 1'b1;
		do next_cycle(); while (!bbox_ack_o);
		bbox_req_i = 1'b0;                  // phase 3
		do next_cycle(); while (bbox_ack_o);
	endtask

	function automatic int box_cost(input oflow_pkg::feat_t a, input oflow_pkg::feat_t b);
		int c;
		c = (a.cx > b.cx ? a.cx - b.cx : b.cx - a.cx) + (a.cy > b.cy ? a.cy - b.cy : b.cy - a.cy)
		  + (a.w > b.w ? a.w - b.w : b.w - a.w) + (a.h > b.h ? a.h - b.h : b.h - a.h);
		if (a.color != b.color)
			c += `OFLOW_COLOR_PENALTY;
		return c;
	endfunction

	// predicts one result and advances the model in box arrival order
	task automatic predict(input oflow_pkg::bbox_t b, output oflow_pkg::track_t t);
		oflow_pkg::feat_t f;
		int cost;
		int best_cost;
		int best_idx;
		f = '{cx: b.x + (b.w >> 1), cy: b.y + (b.h >> 1), w: b.w, h: b.h,
		      color: b.color, last: b.last};
		best_cost = 1 << 30;
		best_idx  = 0;
		for (int i = 0; i < MAX; i++) begin
			if (m_prev_valid[i] && !m_claim[i]) begin
				cost = box_cost(f, m_prev_feat[i]);
				if (cost < best_cost) begin   // first index keeps a tie
					best_cost = cost;
					best_idx  = i;
				end
			end
		end
		t.frame_num = m_frame;
		t.last      = b.last;
		if (best_cost <= `OFLOW_MATCH_TH) begin
			t.id              = m_prev_id[best_idx];
			t.new_track       = 1'b0;
			m_claim[best_idx] = 1'b1;
		end else begin
			t.id        = m_next_id;
			t.new_track = 1'b1;
			m_next_id++;
		end
		if (m_cur_cnt < MAX) begin
			m_cur_feat[m_cur_cnt] = f;
			m_cur_id[m_cur_cnt]   = t.id;
			m_cur_cnt++;
		end
		if (b.last) begin   // the frame closes and history rolls over
			for (int i = 0; i < MAX; i++) begin
				m_prev_feat[i]  = m_cur_feat[i];
				m_prev_id[i]    = m_cur_id[i];
				m_prev_valid[i] = (i < m_cur_cnt);
				m_claim[i]      = 1'b0;
			end
			m_cur_cnt = 0;
			m_frame++;
		end
	endtask

	// ----------------------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------------------
	task automatic check_track(input string name, input oflow_pkg::track_t exp,
	                           input oflow_pkg::track_t act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("Error %s: expected id/frame/new/last %0d/%0d/%b/%b, actual %0d/%0d/%b/%b",
			         name, exp.id, exp.frame_num, exp.new_track, exp.last,
			         act.id, act.frame_num, act.new_track, act.last);
		end
	endtask

	task automatic check_level(input string name, input string sig, input logic exp,
	                           input logic act);
		check_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("Error %s: %s expected %b actual %b", name, sig, exp, act);
		end
	endtask

	task automatic collect_track(input string name, input oflow_pkg::track_t exp,
	                             input int max_delay);
		int delay;
		do next_cycle(); while (!track_req_o);
		check_track(name, exp, track_o);
		delay = {$random(seed)} % (max_delay + 1);   // 0 when no delay asked
		repeat (delay) next_cycle();
		track_ack_i = 1'b1;
		do next_cycle(); while (track_req_o);
		track_ack_i = 1'b0;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		test_cnt++;
		$display("%s: %s", name, (err_cnt == errs_before) ? "passed" : "failed");
	endtask

	// sends box_q and collects the results in parallel
	task automatic run_boxes(input string name, input int max_delay);
		oflow_pkg::track_t exp_q [$];
		oflow_pkg::track_t t;
		foreach (box_q[i]) begin
			predict(box_q[i], t);
			exp_q.push_back(t);
		end
		fork
			begin
				foreach (box_q[i]) send_box(box_q[i]);
			end
			begin
				foreach (exp_q[i]) collect_track(name, exp_q[i], max_delay);
			end
		join
		box_q.delete();
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task automatic check_reset_idle();
		int errs;
		errs = err_cnt;
		check_level("reset_idle", "bbox_ack_o", 1'b0, bbox_ack_o);
		repeat (IDLE_CYCLES) begin
			next_cycle();
			check_level("reset_idle", "track_req_o", 1'b0, track_req_o);   // nothing comes out
		end
		finish_test("reset_idle", errs);
	endtask

	task automatic track_first_frame();
		int errs;
		errs = err_cnt;
		box_q.push_back(build_box(10, 20, 16, 12, 1, 0));
		box_q.push_back(build_box(60, 40, 20, 20, 2, 0));
		box_q.push_back(build_box(120, 100, 10, 30, 3, 1));
		run_boxes("first_frame", 0);
		finish_test("first_frame", errs);
	endtask

	task automatic rematch_reversed();
		int errs;
		errs = err_cnt;
		box_q.push_back(build_box(122, 103, 10, 30, 3, 0));   // shifted and in reverse order
		box_q.push_back(build_box(62, 43, 20, 20, 2, 0));
		box_q.push_back(build_box(13, 22, 16, 12, 1, 1));
		run_boxes("second_frame_reversed", 0);
		finish_test("second_frame_reversed", errs);
	endtask

	task automatic reject_changed_boxes();
		int errs;
		errs = err_cnt;
		box_q.push_back(build_box(16, 25, 16, 12, 9, 0));     // color changed
		box_q.push_back(build_box(100, 43, 20, 20, 2, 0));    // moved far
		box_q.push_back(build_box(122, 103, 10, 30, 3, 1));
		run_boxes("color_and_motion", 0);
		finish_test("color_and_motion", errs);
	endtask

	task automatic resolve_conflict();
		int errs;
		errs = err_cnt;
		box_q.push_back(build_box(17, 25, 16, 12, 9, 0));     // both near one track
		box_q.push_back(build_box(18, 26, 16, 12, 9, 0));
		box_q.push_back(build_box(123, 103, 10, 30, 3, 1));
		run_boxes("match_conflict", 0);
		finish_test("match_conflict", errs);
	endtask

	task automatic stress_back_pressure();
		int errs;
		errs = err_cnt;
		box_q.push_back(build_box(17, 26, 16, 12, 9, 0));
		box_q.push_back(build_box(124, 104, 10, 30, 3, 0));
		box_q.push_back(build_box(200, 10, 8, 8, 5, 0));
		box_q.push_back(build_box(40, 200, 12, 6, 7, 1));
		run_boxes("back_pressure", MAX_ACK_DELAY);
		repeat (10) begin
			next_cycle();
			check_level("back_pressure", "track_req_o", 1'b0, track_req_o);   // no extra result
		end
		finish_test("back_pressure", errs);
	endtask

	// ----------------------------------------------------------------------
	// main sequence and watchdog
	// ----------------------------------------------------------------------
	initial begin
		arst_n_i    = 1'b0;
		bbox_req_i  = 1'b0;
		bbox_i      = '0;
		track_ack_i = 1'b0;
		for (int i = 0; i < MAX; i++) begin
			m_prev_valid[i] = 1'b0;
			m_claim[i]      = 1'b0;
		end
		repeat (10) @(posedge clk);
		#1;
		arst_n_i = 1'b1;
		check_reset_idle();
		track_first_frame();
		rematch_reversed();
		reject_changed_boxes();
		resolve_conflict();
		stress_back_pressure();
		if (u_dut.u_checker.fail_cnt != 0)
			$display("handshake checker flagged %0d assertion failures",
			         u_dut.u_checker.fail_cnt);
		err_cnt += u_dut.u_checker.fail_cnt;
		$display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk);
		$display("watchdog: the tests did not finish within %0d cycles", WATCHDOG_CYC);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: sim.f
+incdir+design
design/oflow_pkg.sv
design/oflow_feature_extract.sv
design/oflow_feature_fifo.sv
design/oflow_registration.sv
design/oflow_core.sv
verif/oflow_core_checker.sv
verif/oflow_core_tb.sv
